// ==== bench/ddr_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_model #(
    parameter int DEPTH     = 40,
    parameter int BASE_ADDR = 0
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic                                     req,
    input  wire logic [ins_fetch_pkg::DDR_ADDR_WIDTH-1:0] addr,
    input  wire logic [ins_fetch_pkg::LEN_WIDTH-1:0]      len,
    output logic [ins_fetch_pkg::ISA_WIDTH-1:0]           data,
    output logic                                          data_valid
);

    localparam int NUM_FLOW = 4;

    // Control-flow words of the program as address, opcode and target
    int flow_addr [NUM_FLOW] = '{3, 9, 20, 37};
    logic [ins_fetch_pkg::OPCODE_WIDTH-1:0] flow_op [NUM_FLOW] =
        '{ins_fetch_pkg::OP_JUMP, ins_fetch_pkg::OP_JUMP,
          ins_fetch_pkg::OP_HALT, ins_fetch_pkg::OP_JUMP};
    int flow_target [NUM_FLOW] = '{35, 12, 0, 5};

    logic [ins_fetch_pkg::ISA_WIDTH-1:0] image [DEPTH];

    logic [31:0] rnd;
    logic [1:0]  gap;
    int          cur;
    int          remaining;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Ordinary words never carry opcode 7 or 15
    initial begin
        ins_fetch_pkg::isa_word_t word;
        for (int i = 0; i < DEPTH; i++) begin
            word.fields.opcode   = 4'(i % 7);
            word.fields.cam_addr = 8'(i * 29 + 3);
            word.fields.oprand_2 = 2'(i);
            word.fields.mem_addr = 16'(i * 977 + 16'h5a00);
            for (int k = 0; k < NUM_FLOW; k++) begin
                if (flow_addr[k] == i) begin
                    word.fields.opcode   = flow_op[k];
                    word.fields.mem_addr = 16'(flow_target[k]);
                end
            end
            image[i] = word.raw;
        end
    end

    // One beat per word with 0 to 3 idle cycles before each
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            data       <= '0;
            data_valid <= 1'b0;
            rnd        <= 32'd30066;
            gap        <= '0;
            cur        <= 0;
            remaining  <= 0;
        end else begin
            data_valid <= 1'b0;
            if (req) begin
                cur       <= addr - BASE_ADDR;
                remaining <= len;
                gap       <= 2'(xorshift(rnd));
                rnd       <= xorshift(rnd);
            end else if (remaining > 0) begin
                if (gap != 0) begin
                    gap <= gap - 1'b1;
                end else begin
                    data       <= image[cur];
                    data_valid <= 1'b1;
                    cur        <= cur + 1;
                    remaining  <= remaining - 1;
                    gap        <= 2'(xorshift(rnd));
                    rnd        <= xorshift(rnd);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_ins_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ins_fetch;

    localparam int ISA_DEPTH       = 16;
    localparam int TOTAL_ISA_DEPTH = 40;
    localparam int ISA_BASE_ADDR   = 1000;
    localparam int TRACE_LEN       = 21;
    localparam int TIMEOUT_CYCLES  = TRACE_LEN * 80;

    // Execution order and ready stall per instruction
    int trace_addr [TRACE_LEN] = '{0, 1, 2, 3, 35, 36, 37, 5, 6, 7, 8, 9,
                                   12, 13, 14, 15, 16, 17, 18, 19, 20};
    int trace_stall [TRACE_LEN] = '{0, 2, 0, 1, 3, 0, 0, 1, 0, 4, 0, 2,
                                    0, 0, 1, 0, 0, 3, 0, 1, 2};

    logic                                     clk = 1'b0;
    logic                                     rst;
    logic                                     run;
    logic                                     ins_ready;
    logic [ins_fetch_pkg::ISA_WIDTH-1:0]      instruction;
    logic                                     ins_valid;
    logic                                     halted;
    logic                                     ddr_rd_req;
    logic [ins_fetch_pkg::DDR_ADDR_WIDTH-1:0] ddr_rd_addr;
    logic [ins_fetch_pkg::LEN_WIDTH-1:0]      ddr_rd_len;
    logic [ins_fetch_pkg::ISA_WIDTH-1:0]      ddr_rd_data;
    logic                                     ddr_rd_valid;

    int cycles    = 0;
    int sample_no = 0;
    int last_beat = 0;
    int req_seen  = 0;
    int exp_base  = 0;

    ins_fetch_top #(
        .ISA_DEPTH       (ISA_DEPTH),
        .TOTAL_ISA_DEPTH (TOTAL_ISA_DEPTH),
        .ISA_BASE_ADDR   (ISA_BASE_ADDR)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .ins_ready    (ins_ready),
        .instruction  (instruction),
        .ins_valid    (ins_valid),
        .halted       (halted),
        .ddr_rd_req   (ddr_rd_req),
        .ddr_rd_addr  (ddr_rd_addr),
        .ddr_rd_len   (ddr_rd_len),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_rd_valid (ddr_rd_valid)
    );

    ddr_model #(
        .DEPTH     (TOTAL_ISA_DEPTH),
        .BASE_ADDR (ISA_BASE_ADDR)
    ) mem_model (
        .clk        (clk),
        .rst        (rst),
        .req        (ddr_rd_req),
        .addr       (ddr_rd_addr),
        .len        (ddr_rd_len),
        .data       (ddr_rd_data),
        .data_valid (ddr_rd_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the trace did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Last block is cut at the program end
    function automatic int burst_length(input int base);
        return (TOTAL_ISA_DEPTH - base < ISA_DEPTH) ? TOTAL_ISA_DEPTH - base : ISA_DEPTH;
    endfunction

    task automatic watch_memory_bus();
        if (ddr_rd_req) begin
            req_seen++;
            check_value(ddr_rd_addr, ISA_BASE_ADDR + exp_base, "burst address");
            check_value(ddr_rd_len, burst_length(exp_base), "burst length");
        end
        if (ddr_rd_valid) begin
            last_beat = sample_no;
        end
    endtask

    // Drive on the rising edge and sample on the falling edge
    task automatic advance(input logic ready);
        @(posedge clk);
        ins_ready <= ready;
        @(negedge clk);
        sample_no++;
        watch_memory_bus();
    endtask

    initial begin
        int addr;
        int blk;
        int resident;
        int misses;
        logic [ins_fetch_pkg::ISA_WIDTH-1:0] exp_word;

        rst       = 1'b0;
        run       = 1'b0;
        ins_ready = 1'b0;
        resident  = -1;
        misses    = 0;
        exp_word  = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        run <= 1'b1;
        // First fetch cycle
        advance(1'b0);

        for (int i = 0; i < TRACE_LEN; i++) begin
            addr     = trace_addr[i];
            blk      = addr / ISA_DEPTH;
            exp_base = blk * ISA_DEPTH;
            exp_word = mem_model.image[addr];
            advance(1'b0);
            if (blk != resident) begin
                check_value(ins_valid, 1'b0, "ins_valid cleared on a miss");
                check_value(ddr_rd_req, 1'b1, "burst request after a miss");
                misses++;
                while (!ins_valid) begin
                    advance(1'b0);
                end
                check_value(sample_no - last_beat, 2, "miss latency from last beat");
                resident = blk;
            end else begin
                check_value(ddr_rd_req, 1'b0, "no burst request on a hit");
                check_value(ins_valid, 1'b1, "ins_valid one cycle after a hit fetch");
            end
            check_value(instruction, exp_word, "delivered instruction");
            repeat (trace_stall[i]) begin
                advance(1'b0);
                check_value(ins_valid, 1'b1, "ins_valid held during a stall");
                check_value(instruction, exp_word, "instruction held during a stall");
            end
            // Take cycle
            advance(1'b1);
            check_value(ins_valid, 1'b1, "ins_valid at the take");
            check_value(instruction, exp_word, "instruction at the take");
            check_value(halted, 1'b0, "halted before the halt is taken");
            advance(1'b0);
        end

        // Nothing is fetched after the halt even with ready high
        check_value(halted, 1'b1, "halted after the halt is taken");
        repeat (20) begin
            advance(1'b1);
            check_value(halted, 1'b1, "halted stays high");
            check_value(instruction, exp_word, "instruction after the halt");
        end
        check_value(req_seen, misses, "number of burst requests");

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/ddr_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ddr_rd_if;

    logic                                     req;
    logic [ins_fetch_pkg::DDR_ADDR_WIDTH-1:0] addr;
    logic [ins_fetch_pkg::LEN_WIDTH-1:0]      len;
    logic [ins_fetch_pkg::ISA_WIDTH-1:0]      data;
    logic                                     data_valid;

    // Burst requester
    modport cache (
        output req, addr, len,
        input  data, data_valid
    );

    // Burst responder
    modport mem (
        input  req, addr, len,
        output data, data_valid
    );

endinterface

`default_nettype wire

// ==== design/ins_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module ins_cache #(
    parameter int ISA_DEPTH       = 128,
    parameter int TOTAL_ISA_DEPTH = 128,
    parameter int ISA_BASE_ADDR   = 0
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic [ins_fetch_pkg::ADDR_WIDTH_MEM-1:0] addr_ins,
    input  wire logic                                     fetch,
    output ins_fetch_pkg::isa_word_t                      instruction,
    output logic                                          ins_valid,
    ddr_rd_if.cache                                       ddr
);

    localparam int OFF_W  = $clog2(ISA_DEPTH);
    localparam int ADDR_W = ins_fetch_pkg::ADDR_WIDTH_MEM;

    logic [ins_fetch_pkg::ISA_WIDTH-1:0] mem [ISA_DEPTH];

    logic [ADDR_W-1:0] addr_reg;
    logic [ADDR_W-1:0] addr_cur;
    logic [ADDR_W-1:0] block_base;
    logic [OFF_W-1:0]  rd_offset;
    logic [OFF_W-1:0]  fill_index;
    logic              hit;
    logic              fill_done;
    logic              load_start;
    logic              tag_load;
    logic              send;
    logic              busy;

    ins_cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .hit        (hit),
        .fill_done  (fill_done),
        .load_start (load_start),
        .tag_load   (tag_load),
        .send       (send),
        .busy       (busy),
        .ddr        (ddr)
    );

    ins_cache_addr_calc #(
        .ISA_DEPTH       (ISA_DEPTH),
        .TOTAL_ISA_DEPTH (TOTAL_ISA_DEPTH),
        .ISA_BASE_ADDR   (ISA_BASE_ADDR)
    ) u_addr_calc (
        .clk        (clk),
        .rst        (rst),
        .addr_ins   (addr_cur),
        .load_start (load_start),
        .tag_load   (tag_load),
        .data_valid (ddr.data_valid),
        .hit        (hit),
        .block_base (block_base),
        .burst_len  (ddr.len),
        .ddr_addr   (ddr.addr),
        .fill_index (fill_index),
        .fill_done  (fill_done)
    );

    // Live address in the fetch cycle and the held one while a miss is served
    assign addr_cur  = busy ? addr_reg : addr_ins;
    assign rd_offset = OFF_W'(addr_cur - block_base);

    always_ff @(posedge clk) begin
        if (fetch) begin
            addr_reg <= addr_ins;
        end
    end

    always_ff @(posedge clk) begin
        if (ddr.data_valid) begin
            mem[fill_index] <= ddr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            instruction.raw <= mem[rd_offset];
        end
    end

    // Held until the next fetch takes it away
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ins_valid <= 1'b0;
        end else if (send) begin
            ins_valid <= 1'b1;
        end else if (fetch) begin
            ins_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/ins_cache_addr_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module ins_cache_addr_calc #(
    parameter int ISA_DEPTH       = 128,
    parameter int TOTAL_ISA_DEPTH = 128,
    parameter int ISA_BASE_ADDR   = 0
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic [ins_fetch_pkg::ADDR_WIDTH_MEM-1:0] addr_ins,
    input  wire logic                                     load_start,
    input  wire logic                                     tag_load,
    input  wire logic                                     data_valid,
    output logic                                          hit,
    output logic [ins_fetch_pkg::ADDR_WIDTH_MEM-1:0]      block_base,
    output logic [ins_fetch_pkg::LEN_WIDTH-1:0]           burst_len,
    output logic [ins_fetch_pkg::DDR_ADDR_WIDTH-1:0]      ddr_addr,
    output logic [$clog2(ISA_DEPTH)-1:0]                  fill_index,
    output logic                                          fill_done
);

    localparam int OFF_W  = $clog2(ISA_DEPTH);
    localparam int ADDR_W = ins_fetch_pkg::ADDR_WIDTH_MEM;
    localparam int LEN_W  = ins_fetch_pkg::LEN_WIDTH;
    localparam int DDR_W  = ins_fetch_pkg::DDR_ADDR_WIDTH;

    logic [ADDR_W-1:0] tag;
    logic              tag_valid;
    logic [ADDR_W:0]   remain;
    logic [LEN_W-1:0]  fill_cnt;

    assign block_base = {addr_ins[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign hit        = tag_valid && (tag == block_base);

    // Last block is cut to the program end
    assign remain    = (ADDR_W + 1)'(TOTAL_ISA_DEPTH) - {1'b0, block_base};
    assign burst_len = (remain > ISA_DEPTH) ? LEN_W'(ISA_DEPTH) : LEN_W'(remain);
    assign ddr_addr  = DDR_W'(ISA_BASE_ADDR) + DDR_W'(block_base);

    assign fill_index = fill_cnt[OFF_W-1:0];
    assign fill_done  = data_valid && (fill_cnt == burst_len - 1'b1);

    // Block is invalid while it is being refilled
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag       <= '0;
            tag_valid <= 1'b0;
        end else if (load_start) begin
            tag_valid <= 1'b0;
        end else if (tag_load) begin
            tag       <= block_base;
            tag_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fill_cnt <= '0;
        end else if (load_start) begin
            fill_cnt <= '0;
        end else if (data_valid) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/ins_cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ins_cache_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic fetch,
    input  wire logic hit,
    input  wire logic fill_done,
    output logic      load_start,
    output logic      tag_load,
    output logic      send,
    output logic      busy,
    ddr_rd_if.cache   ddr
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] LOAD = 2'd1;
    localparam logic [1:0] SEND = 2'd2;

    logic [1:0] state;
    logic [1:0] state_next;
    logic       start_q;
    logic       miss;

    assign miss = (state == IDLE) && fetch && !hit;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    state_next = LOAD;
                end
            end
            LOAD: begin
                if (fill_done) begin
                    state_next = SEND;
                end
            end
            SEND: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // One-cycle burst request a cycle after the missing fetch
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= miss;
        end
    end

    assign ddr.req    = start_q;
    assign load_start = start_q;

    // A hit is served straight from IDLE
    assign send     = ((state == IDLE) && fetch && hit) || (state == SEND);
    assign tag_load = state == SEND;
    assign busy     = state != IDLE;

endmodule

`default_nettype wire

// ==== design/ins_fetch_pkg.sv ====
`default_nettype none

package ins_fetch_pkg;

    // Instruction word fields
    localparam int OPCODE_WIDTH   = 4;
    localparam int ADDR_WIDTH_CAM = 8;
    localparam int OPRAND_2_WIDTH = 2;
    localparam int ADDR_WIDTH_MEM = 16;
    localparam int ISA_WIDTH      = OPCODE_WIDTH + ADDR_WIDTH_CAM
                                  + OPRAND_2_WIDTH + ADDR_WIDTH_MEM;

    // External memory side
    localparam int DDR_ADDR_WIDTH = 28;
    localparam int LEN_WIDTH      = 10;

    // Opcodes handled by the program counter
    localparam logic [OPCODE_WIDTH-1:0] OP_JUMP = 4'b0111;
    localparam logic [OPCODE_WIDTH-1:0] OP_HALT = 4'b1111;

    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]   opcode;
        logic [ADDR_WIDTH_CAM-1:0] cam_addr;
        logic [OPRAND_2_WIDTH-1:0] oprand_2;
        logic [ADDR_WIDTH_MEM-1:0] mem_addr;
    } isa_fields_t;

    // Raw bits for storage and fields for decode
    typedef union packed {
        logic [ISA_WIDTH-1:0] raw;
        isa_fields_t          fields;
    } isa_word_t;

endpackage

`default_nettype wire

// ==== design/ins_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ins_fetch_top #(
    parameter int ISA_DEPTH       = 128,
    parameter int TOTAL_ISA_DEPTH = 128,
    parameter int ISA_BASE_ADDR   = 0
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,

    // Execution side
    input  wire logic                                     run,
    input  wire logic                                     ins_ready,
    output logic [ins_fetch_pkg::ISA_WIDTH-1:0]           instruction,
    output logic                                          ins_valid,
    output logic                                          halted,

    // External memory
    output logic                                          ddr_rd_req,
    output logic [ins_fetch_pkg::DDR_ADDR_WIDTH-1:0]      ddr_rd_addr,
    output logic [ins_fetch_pkg::LEN_WIDTH-1:0]           ddr_rd_len,
    input  wire logic [ins_fetch_pkg::ISA_WIDTH-1:0]      ddr_rd_data,
    input  wire logic                                     ddr_rd_valid
);

    ins_fetch_pkg::isa_word_t                 ins_word;
    logic [ins_fetch_pkg::ADDR_WIDTH_MEM-1:0] addr_ins;
    logic                                     fetch;

    ddr_rd_if ddr_bus ();

    pc_unit u_pc_unit (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .ins_ready   (ins_ready),
        .instruction (ins_word),
        .ins_valid   (ins_valid),
        .addr_ins    (addr_ins),
        .fetch       (fetch),
        .halted      (halted)
    );

    ins_cache #(
        .ISA_DEPTH       (ISA_DEPTH),
        .TOTAL_ISA_DEPTH (TOTAL_ISA_DEPTH),
        .ISA_BASE_ADDR   (ISA_BASE_ADDR)
    ) u_ins_cache (
        .clk         (clk),
        .rst         (rst),
        .addr_ins    (addr_ins),
        .fetch       (fetch),
        .instruction (ins_word),
        .ins_valid   (ins_valid),
        .ddr         (ddr_bus.cache)
    );

    assign instruction = ins_word.raw;

    // Interface to plain memory ports
    assign ddr_rd_req         = ddr_bus.req;
    assign ddr_rd_addr        = ddr_bus.addr;
    assign ddr_rd_len         = ddr_bus.len;
    assign ddr_bus.data       = ddr_rd_data;
    assign ddr_bus.data_valid = ddr_rd_valid;

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 run,
    input  wire logic                                 ins_ready,
    input  wire ins_fetch_pkg::isa_word_t             instruction,
    input  wire logic                                 ins_valid,
    output logic [ins_fetch_pkg::ADDR_WIDTH_MEM-1:0]  addr_ins,
    output logic                                      fetch,
    output logic                                      halted
);

    logic [ins_fetch_pkg::ADDR_WIDTH_MEM-1:0] pc;
    logic                                     running;
    logic                                     take;
    logic                                     is_jump;
    logic                                     is_halt;

    // ins_valid still shows the old word during the fetch cycle
    assign take    = running && ins_valid && ins_ready && !fetch;
    assign is_jump = instruction.fields.opcode == ins_fetch_pkg::OP_JUMP;
    assign is_halt = instruction.fields.opcode == ins_fetch_pkg::OP_HALT;

    assign addr_ins = pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc      <= '0;
            running <= 1'b0;
            fetch   <= 1'b0;
            halted  <= 1'b0;
        end else begin
            fetch <= 1'b0;
            if (!running && !halted && run) begin
                // First fetch is at address 0
                running <= 1'b1;
                fetch   <= 1'b1;
            end else if (take) begin
                if (is_halt) begin
                    running <= 1'b0;
                    halted  <= 1'b1;
                end else begin
                    fetch <= 1'b1;
                    if (is_jump) begin
                        pc <= instruction.fields.mem_addr;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/ins_fetch_pkg.sv
design/ddr_rd_if.sv
design/pc_unit.sv
design/ins_cache_ctrl.sv
design/ins_cache_addr_calc.sv
design/ins_cache.sv
design/ins_fetch_top.sv
bench/ddr_model.sv
bench/tb_ins_fetch.sv
